/* hw/rv_pkg.sv */
package rv_pkg;

    // machine sizes
    localparam int xlen   = 32;
    localparam int nreg   = 32;
    localparam int reg_aw = 5;

    // first fetch address
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_fmt_e;

    // datapath selects
    typedef enum logic {a_sel_rs1, a_sel_pc} alu_a_sel_e;
    typedef enum logic [1:0] {b_sel_rs2, b_sel_imm, b_sel_four} alu_b_sel_e;
    typedef enum logic {base_sel_pc, base_sel_rs1} pc_base_sel_e;
    typedef enum logic {off_sel_four, off_sel_imm} pc_off_sel_e;

endpackage

/* hw/control_unit.sv */
module control_unit (
    input  logic                      rst,
    input  logic [6:0]                opcode,
    input  logic [2:0]                funct3,
    input  logic                      funct7_b5,
    input  logic [rv_pkg::reg_aw-1:0] rd,
    input  logic                      less,
    input  logic                      zero,
    output rv_pkg::imm_fmt_e          imm_fmt,
    output rv_pkg::alu_a_sel_e        alu_a_sel,
    output rv_pkg::alu_b_sel_e        alu_b_sel,
    output rv_pkg::alu_op_e           alu_op,
    output rv_pkg::pc_base_sel_e      pc_base_sel,
    output rv_pkg::pc_off_sel_e       pc_off_sel,
    output logic                      jalr,
    output logic                      wen
);
    import rv_pkg::*;

    alu_op_e arith_op;
    alu_op_e cmp_op;
    logic    taken;
    logic    writes;

    // OP / OP-IMM operation from funct3
    always_comb begin
        case (funct3)
            // sub exists only in register form
            f3_add_sub: arith_op = (funct7_b5 && opcode == opc_op) ? alu_sub : alu_add;
            f3_sll:     arith_op = alu_sll;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            // srai keeps bit 30 in its imm field too
            f3_srl_sra: arith_op = funct7_b5 ? alu_sra : alu_srl;
            f3_or:      arith_op = alu_or;
            default:    arith_op = alu_and;
        endcase
    end

    // branch compare and condition
    always_comb begin
        case (funct3)
            f3_beq: begin
                cmp_op = alu_sub;
                taken  = zero;
            end
            f3_bne: begin
                cmp_op = alu_sub;
                taken  = !zero;
            end
            f3_blt: begin
                cmp_op = alu_slt;
                taken  = less;
            end
            f3_bge: begin
                cmp_op = alu_slt;
                taken  = !less;
            end
            f3_bltu: begin
                cmp_op = alu_sltu;
                taken  = less;
            end
            f3_bgeu: begin
                cmp_op = alu_sltu;
                taken  = !less;
            end
            // reserved encodings fall through
            default: begin
                cmp_op = alu_sub;
                taken  = 1'b0;
            end
        endcase
    end

    always_comb begin
        // defaults give no write and pc plus four
        imm_fmt     = imm_i;
        alu_a_sel   = a_sel_rs1;
        alu_b_sel   = b_sel_rs2;
        alu_op      = alu_add;
        pc_base_sel = base_sel_pc;
        pc_off_sel  = off_sel_four;
        jalr        = 1'b0;
        writes      = 1'b0;
        case (opcode)
            opc_op: begin
                alu_op = arith_op;
                writes = 1'b1;
            end
            opc_op_imm: begin
                alu_b_sel = b_sel_imm;
                alu_op    = arith_op;
                writes    = 1'b1;
            end
            opc_lui: begin
                imm_fmt   = imm_u;
                alu_b_sel = b_sel_imm;
                alu_op    = alu_pass_b;
                writes    = 1'b1;
            end
            opc_auipc: begin
                imm_fmt   = imm_u;
                alu_a_sel = a_sel_pc;
                alu_b_sel = b_sel_imm;
                writes    = 1'b1;
            end
            // link value is pc plus four through the alu
            opc_jal: begin
                imm_fmt    = imm_j;
                alu_a_sel  = a_sel_pc;
                alu_b_sel  = b_sel_four;
                pc_off_sel = off_sel_imm;
                writes     = 1'b1;
            end
            opc_jalr: begin
                alu_a_sel   = a_sel_pc;
                alu_b_sel   = b_sel_four;
                pc_base_sel = base_sel_rs1;
                pc_off_sel  = off_sel_imm;
                jalr        = 1'b1;
                writes      = 1'b1;
            end
            opc_branch: begin
                imm_fmt    = imm_b;
                alu_op     = cmp_op;
                pc_off_sel = taken ? off_sel_imm : off_sel_four;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    // x0 writes dropped here, not in the register file
    assign wen = writes && (rd != '0) && !rst;

endmodule

/* hw/imm_decoder.sv */
module imm_decoder (
    input  logic [rv_pkg::xlen-1:0] cmd,
    input  rv_pkg::imm_fmt_e        imm_fmt,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    // sign bit always sits in cmd[31]
    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{20{cmd[31]}}, cmd[31:20]};
            end
            imm_s: begin
                imm = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
            end
            // branch offset, bit 0 implied zero
            imm_b: begin
                imm = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            end
            // upper 20 bits, low 12 cleared
            imm_u: begin
                imm = {cmd[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* hw/register_file.sv */
module register_file (
    input  logic                      clk,
    input  logic [rv_pkg::reg_aw-1:0] raddr_a,
    input  logic [rv_pkg::reg_aw-1:0] raddr_b,
    input  logic [rv_pkg::reg_aw-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]   wdata,
    input  logic                      wen,
    output logic [rv_pkg::xlen-1:0]   rdata_a,
    output logic [rv_pkg::xlen-1:0]   rdata_b
);
    import rv_pkg::*;

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:nreg-1];

    // write at the edge
    // same-cycle read sees the old word
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // the decoder must never send a write to x0
    waddr_nonzero: assert property (
        @(posedge clk) wen |-> (waddr != '0)
    );

endmodule

/* hw/alu.sv */
module alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    less,
    output logic                    zero
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits count for rv32
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // compare flavour picked by the op
    assign less = (op == alu_sltu) ? lt_unsigned : lt_signed;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            // set-less ops give 0 or 1
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            // lui passes the immediate straight out
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // beq/bne test this after a subtract
    assign zero = (result == '0);

endmodule

/* hw/operand_select.sv */
module operand_select (
    input  rv_pkg::alu_a_sel_e      alu_a_sel,
    input  rv_pkg::alu_b_sel_e      alu_b_sel,
    input  rv_pkg::pc_base_sel_e    pc_base_sel,
    input  rv_pkg::pc_off_sel_e     pc_off_sel,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] imm,
    output logic [rv_pkg::xlen-1:0] alu_a,
    output logic [rv_pkg::xlen-1:0] alu_b,
    output logic [rv_pkg::xlen-1:0] pc_base,
    output logic [rv_pkg::xlen-1:0] pc_off
);
    import rv_pkg::*;

    // alu a side, pc for auipc and link
    assign alu_a = (alu_a_sel == a_sel_pc) ? pc : rs1_data;

    // alu b side
    always_comb begin
        case (alu_b_sel)
            b_sel_imm:  alu_b = imm;
            b_sel_four: alu_b = 32'd4;
            // unused code falls back to rs2
            default:    alu_b = rs2_data;
        endcase
    end

    // next-pc adder inputs
    assign pc_base = (pc_base_sel == base_sel_rs1) ? rs1_data : pc;
    assign pc_off  = (pc_off_sel == off_sel_imm) ? imm : 32'd4;

endmodule

/* hw/pc_reg.sv */
module pc_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] pc_base,
    input  logic [rv_pkg::xlen-1:0] pc_off,
    input  logic                    jalr,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] next_pc;

    assign sum = pc_base + pc_off;

    // jalr target drops bit 0
    assign next_pc = jalr ? {sum[xlen-1:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    // pc still word aligned one cycle after reset release
    pc_aligned_after_reset: assert property (
        @(posedge clk) $fell(rst) |=> (pc[1:0] == 2'b00)
    );

endmodule

/* hw/rv_core.sv */
module rv_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rv_pkg::xlen-1:0]   cmd,
    output logic [rv_pkg::xlen-1:0]   pc,
    output logic                      wb_en,
    output logic [rv_pkg::reg_aw-1:0] wb_addr,
    output logic [rv_pkg::xlen-1:0]   wb_data
);
    import rv_pkg::*;

    // register file data
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;

    // datapath operands
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] pc_base;
    logic [xlen-1:0] pc_off;

    // control
    imm_fmt_e     imm_fmt;
    alu_a_sel_e   alu_a_sel;
    alu_b_sel_e   alu_b_sel;
    alu_op_e      alu_op;
    pc_base_sel_e pc_base_sel;
    pc_off_sel_e  pc_off_sel;
    logic         jalr;
    logic         less;
    logic         zero;

    // rd field doubles as the trace address
    assign wb_addr = cmd[11:7];

    control_unit u_control_unit (
        .rst         (rst),
        .opcode      (cmd[6:0]),
        .funct3      (cmd[14:12]),
        .funct7_b5   (cmd[30]),
        .rd          (wb_addr),
        .less        (less),
        .zero        (zero),
        .imm_fmt     (imm_fmt),
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .alu_op      (alu_op),
        .pc_base_sel (pc_base_sel),
        .pc_off_sel  (pc_off_sel),
        .jalr        (jalr),
        .wen         (wb_en)
    );

    imm_decoder u_imm_decoder (
        .cmd     (cmd),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // write-back straight from the alu
    register_file u_register_file (
        .clk     (clk),
        .raddr_a (cmd[19:15]),
        .raddr_b (cmd[24:20]),
        .waddr   (wb_addr),
        .wdata   (wb_data),
        .wen     (wb_en),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    operand_select u_operand_select (
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .pc_base_sel (pc_base_sel),
        .pc_off_sel  (pc_off_sel),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .pc_base     (pc_base),
        .pc_off      (pc_off)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (wb_data),
        .less   (less),
        .zero   (zero)
    );

    pc_reg u_pc_reg (
        .clk     (clk),
        .rst     (rst),
        .pc_base (pc_base),
        .pc_off  (pc_off),
        .jalr    (jalr),
        .pc      (pc)
    );

endmodule

/* sim/tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int half_period = 50;
    localparam int rst_cycles  = 4;
    // reset loop guard, well past rst_cycles
    localparam int rst_limit   = 16;
    // runaway guard for the stimulus read
    localparam int max_lines   = 256;
    // outputs sampled this long after an edge
    localparam int settle      = 25;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop = 32'h0000_0013;

    logic              clk;
    logic              rst;
    logic [xlen-1:0]   cmd;
    logic [xlen-1:0]   pc;
    logic              wb_en;
    logic [reg_aw-1:0] wb_addr;
    logic [xlen-1:0]   wb_data;

    // one stimulus line
    logic [xlen-1:0]   stim_cmd;
    logic [xlen-1:0]   exp_pc;
    logic              exp_en;
    logic [reg_aw-1:0] exp_addr;
    logic [xlen-1:0]   exp_data;

    int                fd;
    int                fields;
    int                lines;
    int                edges;
    logic              bad_file;

    rv_core u_rv_core (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    // plain-words failure, then stop
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_addr(input string name, input logic [reg_aw-1:0] expected,
                              input logic [reg_aw-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        rst = 1'b1;
        cmd = nop;
        fd  = $fopen("sim/rv_core_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/rv_core_stim.txt for reading");
        end

        // nop under reset, pc parked and trace quiet
        edges = 0;
        while (rst) begin
            @(posedge clk);
            edges = edges + 1;
            #settle;
            check_word("pc", reset_pc, pc);
            check_bit("wb_en", 1'b0, wb_en);
            if (edges == rst_cycles) begin
                // release on a falling edge, first line goes out in the same step
                @(negedge clk);
                rst = 1'b0;
            end else if (edges > rst_limit) begin
                abort_run("timeout while waiting for reset release");
            end
        end

        // one instruction per cycle, driven at the falling edge
        lines  = 0;
        fields = $fscanf(fd, " %h %h %h %h %h", stim_cmd, exp_pc, exp_en, exp_addr, exp_data);
        while (fields == 5) begin
            cmd = stim_cmd;
            #settle;
            check_word("pc", exp_pc, pc);
            check_bit("wb_en", exp_en, wb_en);
            // trace addr and data only count when enabled
            if (exp_en) begin
                check_addr("wb_addr", exp_addr, wb_addr);
                check_word("wb_data", exp_data, wb_data);
            end
            lines = lines + 1;
            if (lines > max_lines) begin
                abort_run("timeout while reading the stimulus file, end never reached");
            end
            @(negedge clk);
            fields = $fscanf(fd, " %h %h %h %h %h",
                             stim_cmd, exp_pc, exp_en, exp_addr, exp_data);
        end

        // a short or garbled line stops the loop before eof
        bad_file = !$feof(fd) || (lines == 0);
        $fclose(fd);
        if (bad_file) begin
            abort_run("stimulus file is empty or holds a malformed line");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* sim/rv_core_stim.txt */
00500093 00000000 1 01 00000005
ffd00113 00000004 1 02 fffffffd
002081b3 00000008 1 03 00000002
40208233 0000000c 1 04 00000008
0020c2b3 00000010 1 05 fffffff8
0020e333 00000014 1 06 fffffffd
0020f3b3 00000018 1 07 00000005
00112433 0000001c 1 08 00000001
001134b3 00000020 1 09 00000000
ffe12513 00000024 1 0a 00000001
876545b7 00000028 1 0b 87654000
00159633 0000002c 1 0c eca80000
0015d6b3 00000030 1 0d 043b2a00
4015d733 00000034 1 0e fc3b2a00
00459793 00000038 1 0f 76540000
0085d813 0000003c 1 10 00876540
4085d893 00000040 1 11 ff876540
12345917 00000044 1 12 12345044
00c009ef 00000048 1 13 0000004c
01598a67 00000054 1 14 00000058
00708463 00000060 0 00 00000000
00208463 00000068 0 00 00000000
00209463 0000006c 0 00 00000000
00709463 00000074 0 00 00000000
00114463 00000078 0 00 00000000
0020c463 00000080 0 00 00000000
0020d463 00000084 0 00 00000000
00115463 0000008c 0 00 00000000
0020e463 00000090 0 00 00000000
00116463 00000098 0 00 00000000
00117463 0000009c 0 00 00000000
0020f463 000000a4 0 00 00000000
00708013 000000a8 0 00 00000000
00000b33 000000ac 1 16 00000000
00a20bb3 000000b0 1 17 00000009

/* verilog.f */
hw/rv_pkg.sv
hw/control_unit.sv
hw/imm_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/operand_select.sv
hw/pc_reg.sv
hw/rv_core.sv
sim/tb_rv_core.sv
